// File: design/cart_pkg.sv
/*
 * Shared widths, memory map and download indices of the cartridge path,
 * with the cheat record type. Design and testbench files import it.
 */
package cart_pkg;

	////////////////////////////////////////
	// Widths

	localparam int dl_addr_w    = 25;  // Download byte address
	localparam int data_w       = 16;
	localparam int mem_addr_w   = 24;  // External memory word address
	localparam int cpu_addr_w   = 23;  // CPU address bits 23:1
	localparam int bank_w       = 5;
	localparam int bank_cnt     = 8;
	localparam int bank_table_w = bank_w * bank_cnt;
	localparam int mask_w       = 11;  // Size mask over address bits 23:13

	////////////////////////////////////////
	// Download stream

	localparam logic [5:0] idx_rom_max = 6'd1;   // Lower 6 index bits, 0 and 1 are ROM
	localparam logic [7:0] idx_cheat   = 8'hFF;

	// Region letter in the cartridge header
	localparam logic [dl_addr_w-1:0] hdr_region_addr = 25'h1F0;

	////////////////////////////////////////
	// Memory map, byte addresses

	localparam logic [23:0] bios_base     = 24'hF00000;
	localparam logic [23:0] cart_rom_base = 24'h000000;
	localparam logic [23:0] work_ram_base = 24'h800000;
	localparam logic [23:0] cart_ram_base = 24'hE00000;

	// Region codes as reported to the host
	localparam logic [1:0] region_jp = 2'd0;
	localparam logic [1:0] region_us = 2'd1;
	localparam logic [1:0] region_eu = 2'd2;

	////////////////////////////////////////
	// Cheat record

	// Words 7/6 hold flags high/low, 5/4 address, 3/2 compare, 1/0 replace.
	// The loader sends the low word of each field first
	typedef union packed {
		logic [7:0][data_w-1:0] words;  // Download slot view
		struct packed {
			logic [31:0] flags;
			logic [31:0] addr;
			logic [31:0] compare;
			logic [31:0] replace;
		} fields;                       // Consumer view
	} cheat_code_u;

endpackage

// File: design/rom_loader.sv
/*
 * ROM download writer. Each accepted ROM word becomes one memory write;
 * the loader is held off through dl_wait until the memory acks.
 */
module rom_loader
	import cart_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  logic                  dl_active,
	input  logic [7:0]            dl_index,
	input  logic                  dl_wr,
	input  logic [dl_addr_w-1:0]  dl_addr,
	input  logic [data_w-1:0]     dl_data,
	input  logic                  cart_mode,
	input  logic                  ld_mem_ack,
	output logic                  dl_wait,
	output logic                  ld_mem_wr,
	output logic [mem_addr_w-1:0] ld_mem_addr,
	output logic [data_w-1:0]     ld_mem_data
);

	logic              rom_wr;
	logic              req;     // Write pending toward memory
	logic [22:1]       addr_q;
	logic [data_w-1:0] data_q;

	assign rom_wr = dl_active & (dl_index[5:0] <= idx_rom_max) & dl_wr;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			req <= 1'b0;
		end else if (req) begin
			if (ld_mem_ack)
				req <= 1'b0;  // Drops the cycle after the ack
		end else if (rom_wr) begin
			req <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rom_wr && !req) begin
			addr_q <= dl_addr[22:1];
			data_q <= {dl_data[7:0], dl_data[15:8]};  // Image is big endian
		end
	end

	// Cartridge images go to the ROM area, anything else is BIOS
	always_comb begin
		if (cart_mode)
			ld_mem_addr = (cart_rom_base >> 1) | mem_addr_w'(addr_q);
		else
			ld_mem_addr = (bios_base >> 1) | mem_addr_w'(addr_q[18:1]);
	end

	assign ld_mem_data = data_q;
	assign ld_mem_wr   = req;
	assign dl_wait     = req;  // Loader stalls for the whole write

endmodule

// File: design/cart_info.sv
/*
 * Watches the ROM download. Latches cartridge mode, grows the ROM size
 * mask from the written addresses and picks the region from the header.
 */
module cart_info
	import cart_pkg::*;
(
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic                 dl_active,
	input  logic [7:0]           dl_index,
	input  logic                 dl_wr,
	input  logic [dl_addr_w-1:0] dl_addr,
	input  logic [data_w-1:0]    dl_data,
	output logic                 cart_mode,
	output logic [mask_w-1:0]    rom_mask,
	output logic [1:0]           region_req,
	output logic                 region_set
);

	logic rom_wr;
	logic hdr_wr;
	logic dl_active_q;

	assign rom_wr = dl_active & (dl_index[5:0] <= idx_rom_max) & dl_wr;
	assign hdr_wr = rom_wr & (dl_addr == hdr_region_addr);

	////////////////////////////////////////
	// Mode and size mask

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cart_mode <= 1'b0;
			rom_mask  <= '0;
		end else if (rom_wr) begin
			cart_mode <= dl_index[6];
			if (dl_index[6]) begin
				if (dl_addr == '0)
					rom_mask <= '0;  // New image starts
				else
					rom_mask <= rom_mask | dl_addr[23:13];
			end
		end
	end

	////////////////////////////////////////
	// Header region letter

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			dl_active_q <= 1'b0;
			region_set  <= 1'b0;
			region_req  <= region_jp;
		end else begin
			dl_active_q <= dl_active;

			if (dl_active && !dl_active_q)
				region_set <= 1'b0;
			if (!dl_active && dl_active_q)
				region_set <= 1'b0;  // Host takes the request at download end

			if (hdr_wr) begin
				region_set <= 1'b1;
				case (dl_data[7:0])
					"J":     region_req <= region_jp;
					"U":     region_req <= region_us;
					default: region_req <= region_eu;
				endcase
			end
		end
	end

endmodule

// File: design/bank_regs.sv
/*
 * Cartridge bank registers. The CPU writes them through the page strobe;
 * only images above 4 MB use banking, others keep the identity map.
 */
module bank_regs
	import cart_pkg::*;
(
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  logic                    dl_active,
	input  logic                    page_ce_n,
	input  logic                    cpu_rnw,
	input  logic [cpu_addr_w-1:0]   cpu_va,
	input  logic [data_w-1:0]       cpu_dout,
	input  logic [mask_w-1:0]       rom_mask,
	output logic [bank_table_w-1:0] bank_table
);

	logic [bank_w-1:0] bank_reg [bank_cnt];
	logic              page_ce_q;
	logic              page_fall;
	logic              big_rom;

	assign page_fall = page_ce_q & ~page_ce_n;
	assign big_rom   = |rom_mask[mask_w-1 -: 2];  // Address bits 23:22 seen

	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			page_ce_q <= 1'b1;
		else
			page_ce_q <= page_ce_n;
	end

	// Slot 0 is fixed, the CPU selects slots 1 to 7 with bits 3:1
	always_ff @(posedge clk_sys) begin
		if (!rst_n || dl_active) begin
			for (int k = 0; k < bank_cnt; k++)
				bank_reg[k] <= bank_w'(k);
		end else if (page_fall && big_rom && !cpu_rnw && (cpu_va[2:0] != 3'd0)) begin
			bank_reg[cpu_va[2:0]] <= cpu_dout[bank_w-1:0];
		end
	end

	always_comb begin
		for (int k = 0; k < bank_cnt; k++)
			bank_table[k*bank_w +: bank_w] = bank_reg[k];
	end

endmodule

// File: design/cpu_addr_map.sv
/*
 * CPU side of the memory map. Picks the region from the chip enables,
 * applies banking and the size mask to ROM reads, and gates the strobes.
 */
module cpu_addr_map
	import cart_pkg::*;
(
	input  logic [cpu_addr_w-1:0]   cpu_va,
	input  logic                    ram_ce_n,
	input  logic                    cart_ram_ce_n,
	input  logic                    cart_rom_ce_n,
	input  logic                    oe_n,
	input  logic                    wrl_n,
	input  logic                    wrh_n,
	input  logic [bank_table_w-1:0] bank_table,
	input  logic [mask_w-1:0]       rom_mask,
	output logic [mem_addr_w-1:0]   cpu_mem_addr,
	output logic                    cpu_mem_rd,
	output logic                    cpu_mem_wrl,
	output logic                    cpu_mem_wrh
);

	logic [bank_w-1:0]     bank_sel;
	logic [cpu_addr_w-1:0] rom_va;   // Banked ROM address, bits 23:1
	logic                  ram_any;

	// 512 KB windows selected by bits 21:19
	assign bank_sel = bank_table[cpu_va[20:18]*bank_w +: bank_w];
	assign rom_va   = {bank_sel, cpu_va[17:0]}
	                & {rom_mask, {(cpu_addr_w - mask_w){1'b1}}};

	always_comb begin
		if (!ram_ce_n)
			cpu_mem_addr = (work_ram_base >> 1) | mem_addr_w'(cpu_va[14:0]);
		else if (!cart_ram_ce_n)
			cpu_mem_addr = (cart_ram_base >> 1) | mem_addr_w'(cpu_va[18:0]);
		else if (!cart_rom_ce_n)
			cpu_mem_addr = (cart_rom_base >> 1) | mem_addr_w'(rom_va[21:0]);
		else
			cpu_mem_addr = (bios_base >> 1) | mem_addr_w'(cpu_va[15:0]);  // Default
	end

	assign ram_any = ~ram_ce_n | ~cart_ram_ce_n;

	assign cpu_mem_rd  = (ram_any | ~cart_rom_ce_n) & ~oe_n;
	assign cpu_mem_wrl = ram_any & ~wrl_n;  // ROM and BIOS are read only
	assign cpu_mem_wrh = ram_any & ~wrh_n;

endmodule

// File: design/cheat_assembler.sv
/*
 * Builds one cheat record from eight download words on the cheat index.
 * cheat_valid marks a complete record; cheat_clear marks a new cheat list.
 */
module cheat_assembler
	import cart_pkg::*;
(
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic                 dl_active,
	input  logic [7:0]           dl_index,
	input  logic                 dl_wr,
	input  logic [dl_addr_w-1:0] dl_addr,
	input  logic [data_w-1:0]    dl_data,
	output cheat_code_u          cheat_code,
	output logic                 cheat_valid,
	output logic                 cheat_clear
);

	logic       code_wr;
	logic [2:0] slot;

	assign code_wr = dl_active & (dl_index == idx_cheat) & dl_wr;

	// Offset 0 lands in word 6, offset 2 in word 7,
	// offset 4 in word 4 and so on down to offset 14 in word 1
	assign slot = {~dl_addr[3:2], dl_addr[1]};

	always_ff @(posedge clk_sys) begin
		if (code_wr)
			cheat_code.words[slot] <= dl_data;
	end

	////////////////////////////////////////
	// Record strobes

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cheat_valid <= 1'b0;
			cheat_clear <= 1'b0;
		end else begin
			cheat_valid <= code_wr && (dl_addr[3:0] == 4'd14);  // Last word of record
			cheat_clear <= code_wr && (dl_addr == '0);          // First word of the list
		end
	end

endmodule

// File: design/cart_top.sv
/*
 * Cartridge path top level. Connects the ROM loader, header watcher,
 * bank registers, CPU address map and cheat assembler.
 */
module cart_top
	import cart_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  rst_n,

	// Download stream
	input  logic                  dl_active,
	input  logic [7:0]            dl_index,
	input  logic                  dl_wr,
	input  logic [dl_addr_w-1:0]  dl_addr,
	input  logic [data_w-1:0]     dl_data,
	output logic                  dl_wait,

	// Load memory port
	output logic                  ld_mem_wr,
	output logic [mem_addr_w-1:0] ld_mem_addr,
	output logic [data_w-1:0]     ld_mem_data,
	input  logic                  ld_mem_ack,

	// CPU bus
	input  logic [cpu_addr_w-1:0] cpu_va,
	input  logic [data_w-1:0]     cpu_dout,
	input  logic                  cpu_rnw,
	input  logic                  page_ce_n,
	input  logic                  ram_ce_n,
	input  logic                  cart_ram_ce_n,
	input  logic                  cart_rom_ce_n,
	input  logic                  oe_n,
	input  logic                  wrl_n,
	input  logic                  wrh_n,
	output logic [mem_addr_w-1:0] cpu_mem_addr,
	output logic                  cpu_mem_rd,
	output logic                  cpu_mem_wrl,
	output logic                  cpu_mem_wrh,

	// Region and cheats
	output logic [1:0]            region_req,
	output logic                  region_set,
	output cheat_code_u           cheat_code,
	output logic                  cheat_valid,
	output logic                  cheat_clear
);

	logic                    cart_mode;
	logic [mask_w-1:0]       rom_mask;
	logic [bank_table_w-1:0] bank_table;

	rom_loader u_rom_loader (
		.clk_sys, .rst_n,
		.dl_active, .dl_index, .dl_wr, .dl_addr, .dl_data,
		.cart_mode, .ld_mem_ack,
		.dl_wait, .ld_mem_wr, .ld_mem_addr, .ld_mem_data
	);

	cart_info u_cart_info (
		.clk_sys, .rst_n,
		.dl_active, .dl_index, .dl_wr, .dl_addr, .dl_data,
		.cart_mode, .rom_mask, .region_req, .region_set
	);

	bank_regs u_bank_regs (
		.clk_sys, .rst_n, .dl_active,
		.page_ce_n, .cpu_rnw, .cpu_va, .cpu_dout,
		.rom_mask, .bank_table
	);

	cpu_addr_map u_cpu_addr_map (
		.cpu_va, .ram_ce_n, .cart_ram_ce_n, .cart_rom_ce_n,
		.oe_n, .wrl_n, .wrh_n,
		.bank_table, .rom_mask,
		.cpu_mem_addr, .cpu_mem_rd, .cpu_mem_wrl, .cpu_mem_wrh
	);

	cheat_assembler u_cheat_assembler (
		.clk_sys, .rst_n,
		.dl_active, .dl_index, .dl_wr, .dl_addr, .dl_data,
		.cheat_code, .cheat_valid, .cheat_clear
	);

endmodule

// File: verification/cart_monitor.sv
/*
 * Watches the DUT ports, records acked memory writes and cheat strobes,
 * and compares them with the expected values the testbench hands over.
 */
module cart_monitor
	import cart_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  ld_mem_wr,
	input  logic                  ld_mem_ack,
	input  logic [mem_addr_w-1:0] ld_mem_addr,
	input  logic [data_w-1:0]     ld_mem_data,
	input  logic [mem_addr_w-1:0] cpu_mem_addr,
	input  logic                  cpu_mem_rd,
	input  logic                  cpu_mem_wrl,
	input  logic                  cpu_mem_wrh,
	input  logic [1:0]            region_req,
	input  logic                  region_set,
	input  cheat_code_u           cheat_code,
	input  logic                  cheat_valid,
	input  logic                  cheat_clear,
	output int                    error_count
);
	timeunit 1ns;
	timeprecision 100ps;

	int          wr_count;
	int          valid_count;
	int          clear_count;
	logic [39:0] last_wr;     // Latest acked write as {address, data}
	cheat_code_u last_cheat;

	initial begin
		error_count = 0;
		wr_count    = 0;
		valid_count = 0;
		clear_count = 0;
	end

	always @(posedge clk_sys) begin
		if (ld_mem_wr && ld_mem_ack) begin
			last_wr  <= {ld_mem_addr, ld_mem_data};
			wr_count <= wr_count + 1;
		end
		if (cheat_valid) begin
			last_cheat  <= cheat_code;  // Record is complete here
			valid_count <= valid_count + 1;
		end
		if (cheat_clear)
			clear_count <= clear_count + 1;
	end

	task automatic compare(input string name, input logic [39:0] exp, input logic [39:0] act);
		if (exp !== act) begin
			$display("[FAIL] %s expected %h actual %h", name, exp, act);
			error_count++;
		end
	endtask

	task automatic mem_write(input string name, input bit value, input logic [39:0] exp,
	                         input int count);
		if (value)
			compare(name, exp, last_wr);
		compare({name, "_count"}, count, wr_count);  // Exactly one write per ROM word
	endtask

	// Strobes as {rd, wrl, wrh}
	task automatic cpu_access(input string name, input logic [2:0] strobes,
	                          input logic [23:0] exp);
		compare(name, {strobes, exp}, {cpu_mem_rd, cpu_mem_wrl, cpu_mem_wrh, cpu_mem_addr});
	endtask

	task automatic region_state(input string name, input logic [1:0] code, input logic set);
		compare(name, {set, code}, {region_set, region_req});
	endtask

	task automatic cheat_strobes(input string name, input logic [15:0] exp);
		compare(name, exp, {valid_count[7:0], clear_count[7:0]});
	endtask

	task automatic cheat_record(input logic [31:0] flags, input logic [31:0] addr,
	                            input logic [31:0] cmp, input logic [31:0] repl);
		compare("cheat_flags", flags, last_cheat.fields.flags);
		compare("cheat_addr", addr, last_cheat.fields.addr);
		compare("cheat_compare", cmp, last_cheat.fields.compare);
		compare("cheat_replace", repl, last_cheat.fields.replace);
	endtask

endmodule

// File: verification/cart_chk.sv
/*
 * Handshake assertions for the ROM loader, bound into every rom_loader
 * instance. Checks the wait flag, request stability and reset state.
 */
module cart_chk
	import cart_pkg::*;
(
	input logic                  clk_sys,
	input logic                  rst_n,
	input logic                  dl_active,
	input logic [7:0]            dl_index,
	input logic                  dl_wr,
	input logic                  dl_wait,
	input logic                  ld_mem_wr,
	input logic                  ld_mem_ack,
	input logic [mem_addr_w-1:0] ld_mem_addr,
	input logic [data_w-1:0]     ld_mem_data
);
	timeunit 1ns;
	timeprecision 100ps;

	int fail_count = 0;

	// Accepted ROM word raises the request and the wait flag together
	req_starts: assert property (@(posedge clk_sys) disable iff (!rst_n)
		dl_active && dl_wr && (dl_index[5:0] <= idx_rom_max) && !dl_wait
		|=> ld_mem_wr && dl_wait)
		else begin
			$error("ROM write accepted without memory request and dl_wait");
			fail_count++;
		end

	// Request waits for its ack with address and data frozen
	req_stable: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ld_mem_wr && !ld_mem_ack |=> ld_mem_wr && $stable(ld_mem_addr) && $stable(ld_mem_data))
		else begin
			$error("Memory request dropped or changed before its ack");
			fail_count++;
		end

	req_ends: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ld_mem_wr && ld_mem_ack |=> !ld_mem_wr && !dl_wait)
		else begin
			$error("Memory request or dl_wait still high after the ack");
			fail_count++;
		end

	wait_after_reset: assert property (@(posedge clk_sys) !rst_n |=> !dl_wait)
		else begin
			$error("dl_wait high after reset");
			fail_count++;
		end

endmodule

bind rom_loader cart_chk u_cart_chk (.*);

// File: verification/tb_cart.sv
/*
 * Testbench for the cartridge path. Runs a table of download, page write
 * and CPU access cases against cart_top and answers memory writes after a
 * random latency. The monitor does all comparing.
 */
module tb_cart
	import cart_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	typedef enum logic [2:0] {k_rom, k_hdr, k_cheat, k_read, k_page, k_ram} kind_e;

	typedef struct packed {
		kind_e       kind;
		logic [7:0]  idx;
		logic [24:0] addr;  // Download address, or CPU byte address
		logic [15:0] data;
		logic [39:0] exp;   // Write {addr, data}, region, strobe counts or CPU address
	} row_t;

	logic                  clk_sys, rst_n;
	logic                  dl_active, dl_wr, dl_wait;
	logic [7:0]            dl_index;
	logic [dl_addr_w-1:0]  dl_addr;
	logic [data_w-1:0]     dl_data, ld_mem_data, cpu_dout;
	logic                  ld_mem_wr, ld_mem_ack;
	logic [mem_addr_w-1:0] ld_mem_addr, cpu_mem_addr;
	logic [cpu_addr_w-1:0] cpu_va;
	logic                  cpu_rnw, page_ce_n, ram_ce_n, cart_ram_ce_n, cart_rom_ce_n;
	logic                  oe_n, wrl_n, wrh_n;
	logic                  cpu_mem_rd, cpu_mem_wrl, cpu_mem_wrh;
	logic [1:0]            region_req;
	logic                  region_set, cheat_valid, cheat_clear;
	cheat_code_u           cheat_code;
	int                    error_count;

	row_t  rows[$];
	string names[$];
	int    exp_writes;
	int    ack_left;
	int    assert_fails;
	bit    timed_out;

	cart_top dut (.*);
	cart_monitor mon (.*);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	////////////////////////////////////////
	// Memory responder

	initial begin
		void'($urandom(33928));  // Fixed seed, same ack latencies every run
		forever begin
			@(posedge clk_sys);
			#2;
			if (ld_mem_ack) begin
				ld_mem_ack = 1'b0;  // Request drops on this edge
			end else if (ld_mem_wr) begin
				if (ack_left == 0)
					ack_left = 1 + int'($urandom % 6);  // 1 to 6 cycles
				ack_left--;
				ld_mem_ack = (ack_left == 0);
			end
		end
	end

	////////////////////////////////////////
	// Stimulus

	task automatic add_case(input string name, input kind_e kind, input logic [7:0] idx,
	                        input logic [24:0] addr, input logic [15:0] data,
	                        input logic [39:0] exp);
		rows.push_back({kind, idx, addr, data, exp});
		names.push_back(name);
	endtask

	// One word in its own download session
	task automatic send_word(input string name, input row_t r);
		int t;
		t = 0;
		dl_active = 1'b1;
		dl_index  = r.idx;
		dl_addr   = r.addr;
		dl_data   = r.data;
		@(posedge clk_sys);
		#2;
		dl_wr = 1'b1;
		@(posedge clk_sys);
		#2;
		dl_wr = 1'b0;
		while (dl_wait && t < 50) begin
			@(posedge clk_sys);
			#2;
			t++;
		end
		if (dl_wait) begin
			$display("Timeout in %s, dl_wait still high after 50 cycles", name);
			timed_out = 1'b1;
		end
	endtask

	task automatic run_case(input string name, input row_t r);
		case (r.kind)
			k_read: begin
				cpu_va        = r.addr[23:1];
				cart_rom_ce_n = 1'b0;
				oe_n          = 1'b0;
				wrl_n         = 1'b0;  // ROM ignores write strobes
				wrh_n         = 1'b0;
				@(negedge clk_sys);  // Map is combinational
				mon.cpu_access(name, 3'b100, r.exp[23:0]);
				@(posedge clk_sys);
				#2;
				cart_rom_ce_n = 1'b1;
				oe_n          = 1'b1;
				wrl_n         = 1'b1;
				wrh_n         = 1'b1;
			end
			k_ram: begin
				cpu_va   = r.addr[23:1];
				ram_ce_n = 1'b0;
				wrl_n    = 1'b0;  // Low byte lane only
				@(negedge clk_sys);
				mon.cpu_access(name, 3'b010, r.exp[23:0]);
				@(posedge clk_sys);
				#2;
				ram_ce_n = 1'b1;
				wrl_n    = 1'b1;
			end
			k_page: begin
				cpu_va    = r.addr[23:1];
				cpu_dout  = r.data;
				cpu_rnw   = 1'b0;
				page_ce_n = 1'b0;
				@(posedge clk_sys);
				#2;
				page_ce_n = 1'b1;
				cpu_rnw   = 1'b1;
			end
			default: begin
				if (r.kind != k_cheat)
					exp_writes++;
				send_word(name, r);
				if (r.kind == k_hdr)
					mon.region_state(name, r.exp[1:0], 1'b1);
				dl_active = 1'b0;
				repeat (2) begin
					@(posedge clk_sys);
					#2;
				end
				if (r.kind == k_hdr)
					mon.region_state({name, "_end"}, r.exp[1:0], 1'b0);
				if (r.kind == k_cheat)
					mon.cheat_strobes(name, r.exp[15:0]);
				mon.mem_write(name, r.kind == k_rom, r.exp, exp_writes);
			end
		endcase
	endtask

	initial begin
		rst_n         = 1'b0;
		dl_active     = 1'b0;
		dl_index      = '0;
		dl_wr         = 1'b0;
		dl_addr       = '0;
		dl_data       = '0;
		ld_mem_ack    = 1'b0;
		cpu_va        = '0;
		cpu_dout      = '0;
		cpu_rnw       = 1'b1;
		page_ce_n     = 1'b1;
		ram_ce_n      = 1'b1;
		cart_ram_ce_n = 1'b1;
		cart_rom_ce_n = 1'b1;
		oe_n          = 1'b1;
		wrl_n         = 1'b1;
		wrh_n         = 1'b1;
		exp_writes    = 0;
		timed_out     = 1'b0;

		// ROM words, byte swapped, cartridge or BIOS placement
		add_case("rom_cart_base", k_rom, 8'h40, 25'h0000000, 16'h1234, 40'h000000_3412);
		add_case("rom_cart_idx1", k_rom, 8'h41, 25'h0000102, 16'h0001, 40'h000081_0100);
		add_case("rom_cart_high", k_rom, 8'h40, 25'h03ABCDE, 16'hA55A, 40'h1D5E6F_5AA5);
		add_case("rom_bios", k_rom, 8'h00, 25'h00DF2AC, 16'hBEEF, 40'h7AF956_EFBE);
		add_case("region_jp", k_hdr, 8'h40, 25'h00001F0, 16'h204A, 40'd0);
		add_case("region_us", k_hdr, 8'h40, 25'h00001F0, 16'h2055, 40'd1);
		add_case("region_eu", k_hdr, 8'h40, 25'h00001F0, 16'h2058, 40'd2);
		// 2 MB image wraps reads and ignores bank writes
		add_case("small_base", k_rom, 8'h40, 25'h0000000, 16'h0102, 40'h000000_0201);
		add_case("small_top", k_rom, 8'h40, 25'h01FFFFE, 16'h0304, 40'h0FFFFF_0403);
		add_case("mask_wrap", k_read, 8'h00, 25'h03C1234, 16'h0000, 40'h0E091A);
		add_case("small_page", k_page, 8'h00, 25'h000000C, 16'h0009, 40'h0);
		add_case("small_bank6", k_read, 8'h00, 25'h0301234, 16'h0000, 40'h08091A);
		// 8 MB image, slot 6 moves to bank 9
		add_case("big_base", k_rom, 8'h40, 25'h0000000, 16'h0506, 40'h000000_0605);
		add_case("big_top", k_rom, 8'h40, 25'h07FFFFE, 16'h0708, 40'h3FFFFF_0807);
		add_case("big_page", k_page, 8'h00, 25'h000000C, 16'h0009, 40'h0);
		add_case("big_bank6", k_read, 8'h00, 25'h0301234, 16'h0000, 40'h24091A);
		add_case("big_bank5", k_read, 8'h00, 25'h0281234, 16'h0000, 40'h14091A);
		// Work RAM write at FF1234
		add_case("ram_write", k_ram, 8'h00, 25'h0FF1234, 16'h0000, 40'h40091A);
		// Cheat words, expected {valid count, clear count}
		add_case("cheat_w0", k_cheat, 8'hFF, 25'h0000000, 16'h0001, 40'h0001);
		add_case("cheat_w2", k_cheat, 8'hFF, 25'h0000002, 16'h8000, 40'h0001);
		add_case("cheat_w4", k_cheat, 8'hFF, 25'h0000004, 16'h5678, 40'h0001);
		add_case("cheat_w6", k_cheat, 8'hFF, 25'h0000006, 16'h00FF, 40'h0001);
		add_case("cheat_w8", k_cheat, 8'hFF, 25'h0000008, 16'h00AA, 40'h0001);
		add_case("cheat_w10", k_cheat, 8'hFF, 25'h000000A, 16'h1234, 40'h0001);
		add_case("cheat_w12", k_cheat, 8'hFF, 25'h000000C, 16'h0055, 40'h0001);
		add_case("cheat_w14", k_cheat, 8'hFF, 25'h000000E, 16'h4321, 40'h0101);

		repeat (2) @(posedge clk_sys);
		#2;
		rst_n = 1'b1;
		mon.compare("reset_state", 5'b0, {dl_wait, ld_mem_wr, region_set, cheat_valid, cheat_clear});

		for (int i = 0; i < rows.size() && !timed_out; i++)
			run_case(names[i], rows[i]);
		mon.cheat_record(32'h8000_0001, 32'h00FF_5678, 32'h1234_00AA, 32'h4321_0055);

		assert_fails = dut.u_rom_loader.u_cart_chk.fail_count;
		$display("Errors %0d, assertion failures %0d, memory writes %0d, cheat records %0d, timeout %0d",
		         error_count, assert_fails, mon.wr_count, mon.valid_count, timed_out);
		if (error_count == 0 && assert_fails == 0 && !timed_out)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// File: verilog.f
design/cart_pkg.sv
design/rom_loader.sv
design/cart_info.sv
design/bank_regs.sv
design/cpu_addr_map.sv
design/cheat_assembler.sv
design/cart_top.sv
verification/cart_monitor.sv
verification/cart_chk.sv
verification/tb_cart.sv

// File: Bender.yml
package:
  name: cart_path

sources:
  - design/cart_pkg.sv
  - design/rom_loader.sv
  - design/cart_info.sv
  - design/bank_regs.sv
  - design/cpu_addr_map.sv
  - design/cheat_assembler.sv
  - design/cart_top.sv
  - target: simulation
    files:
      - verification/cart_monitor.sv
      - verification/cart_chk.sv
      - verification/tb_cart.sv
